// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rtc_reader
FLIST     ?= verilog.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf $(BUILD)

// File: design/i2c_read_master.sv
`timescale 1ns/1ps

// random access single byte read: S, addr+W, index, Sr, addr+R, data, NACK, P
// each bit slot is four quarters, scl low in quarters 0-1 and high in 2-3
module i2c_read_master import rtc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  i2c_req_if.engine bus,
  input  logic      sda_in,
  output logic      scl_oe,
  output logic      sda_oe
);

  i2c_state_t   state_q;
  quarter_cnt_t qcnt_q;      // clocks within a quarter
  logic [1:0]   phase_q;     // quarter within a bit slot
  logic [2:0]   bit_cnt_q;
  logic [1:0]   byte_cnt_q;  // 0 addr+W, 1 index, 2 addr+R
  rtc_byte_t    shift_q;     // tx byte, then rx byte
  logic         ack_err_q;
  logic         done_q;
  logic         qtick;

  assign qtick = (qcnt_q == quarter_cnt_t'(i2c_quarter_cycles - 1));

  assign bus.done    = done_q;
  assign bus.ack_err = ack_err_q;
  assign bus.rdata   = shift_q;  // untouched after the last data bit

  // scl pull from state and quarter
  always_comb begin
    case (state_q)
      i2c_idle:    scl_oe = 1'b0;
      i2c_start:   scl_oe = (phase_q == 2'd3);                      // low after sda fell
      i2c_restart: scl_oe = (phase_q == 2'd0) || (phase_q == 2'd3);
      default:     scl_oe = ~phase_q[1];                            // data slots and stop
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= i2c_idle;
      qcnt_q     <= '0;
      phase_q    <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      shift_q    <= '0;
      ack_err_q  <= 1'b0;
      done_q     <= 1'b0;
      sda_oe     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == i2c_idle) begin
        qcnt_q  <= '0;
        phase_q <= '0;
        if (bus.req) begin  // busy requests never reach here
          state_q   <= i2c_start;
          ack_err_q <= 1'b0;
        end
      end else if (!qtick) begin
        qcnt_q <= qcnt_q + 1'b1;
      end else begin
        qcnt_q  <= '0;
        phase_q <= phase_q + 2'd1;

        // sda moves one quarter after scl fell, or on purpose with scl high
        case (state_q)
          i2c_start: if (phase_q == 2'd0) sda_oe <= 1'b1;  // START
          i2c_send_byte: if (phase_q == 2'd0) sda_oe <= ~shift_q[7];  // msb first
          i2c_restart: if (phase_q == 2'd1) sda_oe <= 1'b1;  // repeated START
          i2c_stop: begin
            if (phase_q == 2'd0)
              sda_oe <= 1'b1;  // low before scl rises
            else if (phase_q == 2'd2)
              sda_oe <= 1'b0;  // STOP
          end
          default: if (phase_q == 2'd0) sda_oe <= 1'b0;  // ack, data, nack: released
        endcase

        // sample mid high
        if (phase_q == 2'd2) begin
          if (state_q == i2c_get_ack)
            ack_err_q <= ack_err_q | sda_in;  // high = no ack
          if (state_q == i2c_recv_byte)
            shift_q <= {shift_q[6:0], sda_in};
        end

        // end of slot
        if (phase_q == 2'd3) begin
          case (state_q)
            i2c_start: begin
              state_q    <= i2c_send_byte;
              shift_q    <= {rtc_dev_addr, 1'b0};  // write
              bit_cnt_q  <= '0;
              byte_cnt_q <= 2'd0;
            end
            i2c_send_byte: begin
              if (bit_cnt_q == 3'd7) begin
                state_q <= i2c_get_ack;
              end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                shift_q   <= {shift_q[6:0], 1'b0};
              end
            end
            i2c_get_ack: begin
              bit_cnt_q <= '0;
              case (byte_cnt_q)
                2'd0: begin
                  state_q    <= i2c_send_byte;
                  shift_q    <= {5'd0, bus.reg_idx};  // register pointer
                  byte_cnt_q <= 2'd1;
                end
                2'd1:    state_q <= i2c_restart;
                default: state_q <= i2c_recv_byte;
              endcase
            end
            i2c_restart: begin
              state_q    <= i2c_send_byte;
              shift_q    <= {rtc_dev_addr, 1'b1};  // read
              bit_cnt_q  <= '0;
              byte_cnt_q <= 2'd2;
            end
            i2c_recv_byte: begin
              if (bit_cnt_q == 3'd7)
                state_q <= i2c_send_nack;  // single byte, so nack it
              else
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            i2c_send_nack: state_q <= i2c_stop;
            i2c_stop: begin
              state_q <= i2c_idle;
              done_q  <= 1'b1;
            end
            default: state_q <= i2c_idle;
          endcase
        end
      end
    end
  end

  // bus released whenever nothing is in flight
  a_idle_released: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == i2c_idle |-> !scl_oe && !sda_oe);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    bus.done |=> !bus.done);

endmodule

// File: design/i2c_req_if.sv
`timescale 1ns/1ps

// one byte read request from the poller, completion back from the i2c engine
interface i2c_req_if import rtc_pkg::*; ();

  logic      req;      // single cycle strobe
  reg_idx_t  reg_idx;  // held from req until done
  logic      done;     // single cycle, end of stop
  logic      ack_err;  // valid with done
  rtc_byte_t rdata;    // valid with done

  modport requester (
    output req, reg_idx,
    input  done, ack_err, rdata
  );

  modport engine (
    input  req, reg_idx,
    output done, ack_err, rdata
  );

endinterface

// File: design/poll_timer.sv
`timescale 1ns/1ps

// slow cadence for rtc polling
module poll_timer import rtc_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  output logic tick
);

  poll_cnt_t cnt_q;  // free running

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      tick  <= 1'b0;
    end else begin
      if (cnt_q == poll_cnt_t'(poll_tick_cycles - 1)) begin
        cnt_q <= '0;  // wrap
        tick  <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
        tick  <= 1'b0;
      end
    end
  end

endmodule

// File: design/rtc_pkg.sv
package rtc_pkg;

  // bus and register widths
  typedef logic [7:0]  rtc_byte_t;      // one rtc register byte
  typedef logic [2:0]  reg_idx_t;       // timekeeping register 0..6
  typedef logic [63:0] display_word_t;  // 20YY MM DD WD HH MM SS

  localparam logic [6:0] rtc_dev_addr = 7'h6F;  // 7-bit i2c address of the rtc
  localparam int unsigned reg_count = 7;        // seconds .. year

  // timing
  localparam int unsigned poll_tick_cycles   = 4096;  // well above one transaction
  localparam int unsigned i2c_quarter_cycles = 16;    // 64 clocks per scl bit

  typedef logic [$clog2(poll_tick_cycles)-1:0]   poll_cnt_t;
  typedef logic [$clog2(i2c_quarter_cycles)-1:0] quarter_cnt_t;

  // valid bits per register, control flags like ST / 12-24 / OSCRUN masked off
  localparam rtc_byte_t reg_mask [reg_count] = '{
    8'h7F,  // seconds
    8'h7F,  // minutes
    8'h3F,  // hours
    8'h07,  // weekday
    8'h7F,  // day
    8'h1F,  // month
    8'hFF   // year
  };

  localparam rtc_byte_t century_byte = 8'h20;  // 20xx

  typedef enum logic [1:0] {poll_idle, poll_request, poll_wait_done} poll_state_t;

  typedef enum logic [2:0] {
    i2c_idle, i2c_start, i2c_send_byte, i2c_get_ack,
    i2c_restart, i2c_recv_byte, i2c_send_nack, i2c_stop
  } i2c_state_t;

endpackage

// File: design/rtc_poll_fsm.sv
`timescale 1ns/1ps

// turns poll ticks into single register reads, round robin over 0..6
module rtc_poll_fsm import rtc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tick,
  i2c_req_if.requester bus,
  output logic        wr_en,
  output reg_idx_t    wr_idx,
  output rtc_byte_t   wr_data,
  output logic        ack_err,
  output logic        time_valid
);

  poll_state_t          state_q;
  reg_idx_t             idx_q;      // register being read
  logic                 req_q;
  logic                 ack_err_q;  // result of last transaction
  logic [reg_count-1:0] seen_q;     // one bit per register written

  assign bus.req     = req_q;
  assign bus.reg_idx = idx_q;  // stable through the whole transaction

  // store write in the done cycle, only for acknowledged reads
  assign wr_en   = (state_q == poll_wait_done) && bus.done && !bus.ack_err;
  assign wr_idx  = idx_q;
  assign wr_data = bus.rdata;

  assign ack_err    = ack_err_q;
  assign time_valid = &seen_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= poll_idle;
      idx_q     <= '0;
      req_q     <= 1'b0;
      ack_err_q <= 1'b0;
      seen_q    <= '0;
    end else begin
      req_q <= 1'b0;
      case (state_q)
        poll_idle: begin
          if (tick) begin  // ticks elsewhere are dropped
            state_q <= poll_request;
            req_q   <= 1'b1;
          end
        end
        poll_request: state_q <= poll_wait_done;  // req already out
        poll_wait_done: begin
          if (bus.done) begin
            state_q   <= poll_idle;
            ack_err_q <= bus.ack_err;
            if (!bus.ack_err)
              seen_q[idx_q] <= 1'b1;
            // advance even on error
            idx_q <= (idx_q == reg_idx_t'(reg_count - 1)) ? '0 : idx_q + 1'b1;
          end
        end
        default: state_q <= poll_idle;
      endcase
    end
  end

  // strobe only comes out of the request state
  a_req_in_request: assert property (@(posedge clk) disable iff (!rst_n)
    bus.req |-> state_q == poll_request);

  // engine never completes something we did not ask for
  a_no_done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == poll_idle |-> !bus.done);

endmodule

// File: design/rtc_reader_top.sv
`timescale 1ns/1ps

// rtc reader: poll timer -> poller -> i2c read engine -> timestamp store
module rtc_reader_top import rtc_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          sda_in,
  output logic          scl_oe,      // high pulls scl low
  output logic          sda_oe,      // high pulls sda low
  output display_word_t time_word,
  output logic          time_valid,
  output logic          ack_err
);

  logic      tick;
  logic      wr_en;
  reg_idx_t  wr_idx;
  rtc_byte_t wr_data;

  i2c_req_if req_bus ();  // poller <-> engine

  poll_timer u_poll_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick)
  );

  rtc_poll_fsm u_poll_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .tick       (tick),
    .bus        (req_bus.requester),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .wr_data    (wr_data),
    .ack_err    (ack_err),
    .time_valid (time_valid)
  );

  i2c_read_master u_i2c_master (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus    (req_bus.engine),
    .sda_in (sda_in),
    .scl_oe (scl_oe),
    .sda_oe (sda_oe)
  );

  timestamp_regs u_timestamp (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .time_word (time_word)
  );

endmodule

// File: design/timestamp_regs.sv
`timescale 1ns/1ps

// seven masked rtc bytes, packed into the bcd display word
module timestamp_regs import rtc_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wr_en,
  input  reg_idx_t      wr_idx,
  input  rtc_byte_t     wr_data,
  output display_word_t time_word
);

  rtc_byte_t regs_q [reg_count];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++)
        regs_q[i] <= '0;
    end else if (wr_en) begin
      regs_q[wr_idx] <= wr_data & reg_mask[wr_idx];  // drop control flags
    end
  end

  // 20 YY MM DD WD HH MM SS, reg 0 in the low byte
  always_comb begin
    time_word[63:56] = century_byte;
    for (int i = 0; i < reg_count; i++)
      time_word[i*8 +: 8] = regs_q[i];
  end

  // poller wraps the index before it reaches 7
  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_idx < reg_count);

endmodule

// File: tests/i2c_rtc_slave.sv
`timescale 1ns/1ps

// behavioral rtc chip at 7'h6F, decodes the bus from clk-sampled edges
module i2c_rtc_slave (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        scl,
  input  logic        sda,
  input  logic [55:0] rtc_bytes,     // register 0 in the low byte
  input  logic        nack_addr,     // withhold the address acknowledge
  output logic        sda_pull,      // high pulls sda low
  output logic        stop_seen,     // one cycle after each STOP
  output logic [7:0]  wr_addr_byte,  // first address byte of the transaction
  output logic [7:0]  idx_byte,      // register pointer as written
  output logic [7:0]  rd_addr_byte,  // address byte after the repeated START
  output int          txn_count
);

  typedef enum logic [1:0] {s_rx, s_ack, s_tx, s_mack} slave_mode_t;

  slave_mode_t mode_q;
  logic        scl_q;
  logic        sda_q;
  logic [3:0]  bit_cnt_q;   // rising edges in the current byte
  logic [1:0]  byte_num_q;  // byte since the last START
  logic [7:0]  shift_q;
  logic [7:0]  tx_q;        // byte being returned
  logic        in_frame_q;
  logic        restarted_q;
  logic        addr_ok_q;
  logic        rd_mode_q;
  logic        addr_match;
  logic [7:0]  sel_byte;

  assign addr_match = (shift_q[7:1] == 7'h6F) && !nack_addr;
  assign sel_byte   = rtc_bytes[idx_byte[2:0]*8 +: 8];  // pointer picks the register

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q <= s_rx;
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      bit_cnt_q <= '0;
      byte_num_q <= '0;
      shift_q <= '0;
      tx_q <= '0;
      in_frame_q <= 1'b0;
      restarted_q <= 1'b0;
      addr_ok_q <= 1'b0;
      rd_mode_q <= 1'b0;
      sda_pull <= 1'b0;
      stop_seen <= 1'b0;
      wr_addr_byte <= '0;
      idx_byte <= '0;
      rd_addr_byte <= '0;
      txn_count <= 0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      stop_seen <= 1'b0;
      if (scl && scl_q && sda_q && !sda) begin  // START or repeated START
        restarted_q <= in_frame_q;
        in_frame_q <= 1'b1;
        mode_q <= s_rx;
        bit_cnt_q <= '0;
        byte_num_q <= '0;
        sda_pull <= 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin  // STOP
        in_frame_q <= 1'b0;
        mode_q <= s_rx;
        sda_pull <= 1'b0;
        stop_seen <= 1'b1;
        txn_count <= txn_count + 1;
      end else if (scl && !scl_q) begin  // rising scl, sample
        if (mode_q == s_rx) begin
          shift_q <= {shift_q[6:0], sda};
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end else if (mode_q == s_tx) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else if (!scl && scl_q) begin  // falling scl, drive
        case (mode_q)
          s_rx: begin
            if (bit_cnt_q == 4'd8) begin
              mode_q <= s_ack;
              if (byte_num_q == 2'd0) begin  // address byte
                addr_ok_q <= addr_match;
                rd_mode_q <= shift_q[0];
                sda_pull <= addr_match;
                if (restarted_q)
                  rd_addr_byte <= shift_q;
                else
                  wr_addr_byte <= shift_q;
              end else begin
                if (byte_num_q == 2'd1 && !restarted_q)
                  idx_byte <= shift_q;  // recorded even when not acked
                sda_pull <= addr_ok_q && !rd_mode_q;
              end
            end
          end
          s_ack: begin
            byte_num_q <= byte_num_q + 1'b1;
            bit_cnt_q <= '0;
            if (addr_ok_q && rd_mode_q) begin
              mode_q <= s_tx;
              tx_q <= sel_byte;
              sda_pull <= !sel_byte[7];  // msb first
            end else begin
              mode_q <= s_rx;
              sda_pull <= 1'b0;
            end
          end
          s_tx: begin
            if (bit_cnt_q == 4'd8) begin
              sda_pull <= 1'b0;  // master nacks
              mode_q <= s_mack;
            end else begin
              sda_pull <= !tx_q[3'd7 - bit_cnt_q[2:0]];
            end
          end
          default: begin
            mode_q <= s_rx;
            bit_cnt_q <= '0;
          end
        endcase
      end
    end
  end

endmodule

// File: tests/rtc_checker.sv
`timescale 1ns/1ps

// reference model of the reader, checks every transaction after its STOP
module rtc_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        scl,
  input  logic        sda,
  input  logic        scl_oe,
  input  logic        sda_oe,
  input  logic [63:0] time_word,
  input  logic        time_valid,
  input  logic        ack_err,
  input  logic        done,
  input  logic        stop_seen,
  input  logic [7:0]  wr_addr_byte,
  input  logic [7:0]  idx_byte,
  input  logic [7:0]  rd_addr_byte,
  input  logic [55:0] rtc_bytes,
  input  logic        nack_addr,
  output int          err_count,
  output int          bus_err_count,
  output int          txn_checked,
  output logic        reset_checked
);

  // valid bits per register: sec, min, hour, wday, day, month, year
  localparam logic [7:0] valid_mask [7] = '{8'h7F, 8'h7F, 8'h3F, 8'h07, 8'h7F, 8'h1F, 8'hFF};

  logic [7:0]  exp_reg [7];
  logic [6:0]  seen;
  int          exp_idx;
  logic        scl_q;
  logic        sda_q;
  logic        in_txn;
  int          starts;

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      err_count++;
    end
  endtask

  initial begin
    int          cnt;
    logic [7:0]  snap_byte;
    logic        snap_nack;
    logic [63:0] exp_word;
    err_count = 0;
    txn_checked = 0;
    reset_checked = 1'b0;
    seen = '0;
    exp_idx = 0;
    for (int i = 0; i < 7; i++)
      exp_reg[i] = '0;
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < 1000) begin
      @(posedge clk);
      cnt++;
    end
    @(posedge clk);
    #1;
    check_value("scl_oe", scl_oe, 0);  // reset state, long before the first tick
    check_value("sda_oe", sda_oe, 0);
    check_value("ack_err", ack_err, 0);
    check_value("time_valid", time_valid, 0);
    check_value("time_word", time_word, {8'h20, 56'h0});
    reset_checked = 1'b1;
    forever begin
      cnt = 0;
      do begin
        @(posedge clk);
        #1;
        cnt++;
      end while (!stop_seen && cnt < 12000);
      if (!stop_seen) begin
        $display("no STOP seen on the bus within %0d cycles", cnt);
        err_count++;
      end else begin
        snap_byte = rtc_bytes[exp_idx*8 +: 8];  // bytes only change while idle
        snap_nack = nack_addr;
        check_value("idx_byte", idx_byte, exp_idx);
        check_value("wr_addr_byte", wr_addr_byte, 8'hDE);  // 6F + write
        check_value("rd_addr_byte", rd_addr_byte, 8'hDF);  // 6F + read
        cnt = 0;
        while (!done && cnt < 200) begin
          @(posedge clk);
          #1;
          cnt++;
        end
        if (!done) begin
          $display("done pulse missing after STOP");
          err_count++;
        end
        @(posedge clk);  // store and error flag update on this edge
        #1;
        if (!snap_nack) begin
          exp_reg[exp_idx] = snap_byte & valid_mask[exp_idx];
          seen[exp_idx] = 1'b1;
        end
        exp_word = {8'h20, 56'h0};
        for (int i = 0; i < 7; i++)
          exp_word[i*8 +: 8] = exp_reg[i];
        check_value("ack_err", ack_err, snap_nack);
        check_value("time_word", time_word, exp_word);
        check_value("time_valid", time_valid, &seen);
        exp_idx = (exp_idx + 1) % 7;
        txn_checked++;
      end
    end
  end

  // bus legality, sda may only move with scl high as START, Sr or STOP
  always @(posedge clk) begin
    if (rst_n !== 1'b1) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      in_txn <= 1'b0;
      starts <= 0;
      bus_err_count <= 0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl != scl_q && sda != sda_q) begin
        $display("bus error at %0t: sda moved on the same edge as scl", $time);
        bus_err_count <= bus_err_count + 1;
      end else if (scl && scl_q && sda_q && !sda) begin
        if (in_txn && starts >= 2) begin
          $display("bus error at %0t: extra START inside a transaction", $time);
          bus_err_count <= bus_err_count + 1;
        end
        in_txn <= 1'b1;
        starts <= in_txn ? starts + 1 : 1;
      end else if (scl && scl_q && !sda_q && sda) begin
        if (!in_txn || starts != 2) begin
          $display("bus error at %0t: STOP without START and repeated START", $time);
          bus_err_count <= bus_err_count + 1;
        end
        in_txn <= 1'b0;
      end
    end
  end

endmodule

// File: tests/tb_rtc_reader.sv
`timescale 1ns/1ps

module tb_rtc_reader;

  logic        clk;
  logic        rst_n;
  logic        scl_oe;
  logic        sda_oe;
  logic [63:0] time_word;
  logic        time_valid;
  logic        ack_err;
  logic [55:0] rtc_bytes;  // slave register contents
  logic        nack_addr;
  logic        sda_pull;
  logic        stop_seen;
  logic [7:0]  wr_addr_byte;
  logic [7:0]  idx_byte;
  logic [7:0]  rd_addr_byte;
  int          txn_count;
  int          err_count;
  int          bus_err_count;
  int          txn_checked;
  logic        reset_checked;
  wire         scl;
  wire         sda;
  integer      seed;
  logic        timed_out;
  int          errs_seen;  // value errors at the end of the previous test
  int          tests_failed;

  assign scl = !scl_oe;               // only the master drives scl
  assign sda = !(sda_oe || sda_pull);  // wired and of both pulls

  rtc_reader_top uut (
    .clk(clk), .rst_n(rst_n), .sda_in(sda), .scl_oe(scl_oe), .sda_oe(sda_oe),
    .time_word(time_word), .time_valid(time_valid), .ack_err(ack_err)
  );

  i2c_rtc_slave slave (
    .clk(clk), .rst_n(rst_n), .scl(scl), .sda(sda), .rtc_bytes(rtc_bytes),
    .nack_addr(nack_addr), .sda_pull(sda_pull), .stop_seen(stop_seen),
    .wr_addr_byte(wr_addr_byte), .idx_byte(idx_byte), .rd_addr_byte(rd_addr_byte),
    .txn_count(txn_count)
  );

  rtc_checker chk (
    .clk(clk), .rst_n(rst_n), .scl(scl), .sda(sda), .scl_oe(scl_oe), .sda_oe(sda_oe),
    .time_word(time_word), .time_valid(time_valid), .ack_err(ack_err),
    .done(uut.u_i2c_master.done_q), .stop_seen(stop_seen), .wr_addr_byte(wr_addr_byte),
    .idx_byte(idx_byte), .rd_addr_byte(rd_addr_byte), .rtc_bytes(rtc_bytes),
    .nack_addr(nack_addr), .err_count(err_count), .bus_err_count(bus_err_count),
    .txn_checked(txn_checked), .reset_checked(reset_checked)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic randomize_bytes();
    logic [31:0] r;
    for (int i = 0; i < 7; i++) begin
      r = $random(seed);
      rtc_bytes[i*8 +: 8] = r[7:0];
    end
  endtask

  // waits until the checker has finished n transactions
  task automatic wait_checks(input int n);
    int cnt;
    cnt = 0;
    while (!timed_out && txn_checked < n && cnt < 12000) begin
      @(negedge clk);
      cnt++;
    end
    if (!timed_out && txn_checked < n) begin
      $display("timeout: transaction %0d was never completed", n);
      timed_out = 1'b1;
    end
  endtask

  // value errors since the previous test, or all bus errors for the bus test
  task automatic report_test(input string name, input bit bus_test);
    int errs;
    errs = bus_test ? bus_err_count : err_count - errs_seen;
    if (errs != 0 || timed_out) begin
      $display("test %s: FAILED (%0d errors)", name, errs);
      tests_failed++;
    end else begin
      $display("test %s: ok", name);
    end
    if (!bus_test)
      errs_seen = err_count;
  endtask

  initial begin
    int cnt;
    seed = 32'hc6d;
    rst_n = 1'b0;
    nack_addr = 1'b0;
    timed_out = 1'b0;
    errs_seen = 0;
    tests_failed = 0;
    randomize_bytes();
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    cnt = 0;
    while (!reset_checked && cnt < 100) begin
      @(negedge clk);
      cnt++;
    end
    if (!reset_checked) begin
      $display("timeout: reset state was never checked");
      timed_out = 1'b1;
    end
    report_test("reset values", 1'b0);

    for (int k = 1; k <= 7; k++)  // one poll period per read
      wait_checks(k);
    report_test("first pass and index order", 1'b0);

    for (int k = 8; k <= 21; k++) begin  // two passes with fresh bytes each time
      @(posedge clk);
      #1 randomize_bytes();
      wait_checks(k);
    end
    report_test("random updates", 1'b0);

    @(posedge clk);
    #1 nack_addr = 1'b1;
    wait_checks(22);
    @(posedge clk);
    #1 nack_addr = 1'b0;  // acknowledge returns
    wait_checks(23);
    report_test("address nack and recovery", 1'b0);

    report_test("bus legality", 1'b1);
    $display("tests failed %0d, errors %0d, transactions %0d", tests_failed,
             err_count + bus_err_count, txn_count);
    if (tests_failed == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/rtc_pkg.sv
design/i2c_req_if.sv
design/poll_timer.sv
design/rtc_poll_fsm.sv
design/i2c_read_master.sv
design/timestamp_regs.sv
design/rtc_reader_top.sv
tests/i2c_rtc_slave.sv
tests/rtc_checker.sv
tests/tb_rtc_reader.sv
